/* verification/csr_trace.txt */
# op addr data expected, all hex; W writes then reads back, R reads, S and F stall or flush a write
# EXC addr=expcode data=era; HWI data=lines; SIG addr 0 wen_csr 1 cpu_interrupt 2 idle_over; TWAIT/TQUIET data=cycles
R 0000 00000000 000000a8
R 0001 00000000 00000000
R 0004 00000000 00000000
R 0005 00000000 00000000
R 0006 00000000 00000000
R 0007 00000000 00000000
R 000c 00000000 00000000
R 0030 00000000 00000000
R 0031 00000000 00000000
R 0032 00000000 00000000
R 0033 00000000 00000000
R 0040 00000000 00000000
R 0041 00000000 00000000
R 0042 00000000 00000000
SIG 0000 00000000 00000000
SIG 0001 00000000 00000000
W 0030 12345678 12345678
W 0031 9abcdef0 9abcdef0
W 0032 00c0ffee 00c0ffee
W 0033 ffffffff ffffffff
W 0040 00000007 00000007
S 0030 a5a5a5a5 12345678
F 0031 11111111 9abcdef0
W 0000 000000b8 000000a8
W 0000 000000af 000000af
EXC 004b 1c000100 00000000
R 0001 00000000 00000007
R 0000 00000000 000000a8
R 0005 00000000 004b0000
R 0006 00000000 1c000100
ERTN 0000 00000000 00000000
R 0000 00000000 000000af
HWI 0000 00000001 00000000
SIG 0002 00000000 00000001
SIG 0001 00000000 00000000
R 0005 00000000 004b0004
W 0004 ffffffff 00001bff
SIG 0001 00000000 00000001
HWI 0000 00000000 00000000
SIG 0002 00000000 00000000
W 0041 00000051 00000051
TWAIT 0000 00000040 00000001
W 0044 00000000 00000000
R 0005 00000000 004b0000
W 0041 00000050 00000050
TQUIET 0000 00000040 00000000
R 0005 00000000 004b0000

/* project.f */
rtl/csr_pkg.sv
rtl/csr_write_seq.sv
rtl/csr_timer.sv
rtl/csr_exc_regs.sv
rtl/csr_save_regs.sv
rtl/csr_read_mux.sv
rtl/csr_top.sv
verification/csr_tb.sv

/* Bender.yml */
package:
  name: csr_core

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_write_seq.sv
  - rtl/csr_timer.sv
  - rtl/csr_exc_regs.sv
  - rtl/csr_save_regs.sv
  - rtl/csr_read_mux.sv
  - rtl/csr_top.sv
  - target: simulation
    files:
      - verification/csr_tb.sv

/* verification/csr_tb.sv */
module csr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IDLE_TIMEOUT = 16;

    logic        clk;
    logic        aresetn;
    logic        wen_in;
    logic [13:0] addr_in;
    logic [31:0] wdata_in;
    logic        d_idle;
    logic        flush_to_priv_wr_csr;
    logic        exception;
    logic        ertn;
    logic [6:0]  expcode_in;
    logic        wen_expcode;
    logic [31:0] era_in;
    logic        wen_era;
    logic [31:0] badv_in;
    logic        wen_badv;
    logic [7:0]  hardware_interrupt;
    logic [31:0] rdata;
    logic [31:0] crmd;
    logic [31:0] estat;
    logic [31:0] era_out;
    logic [31:0] eentry;
    logic [31:0] tid;
    logic        cpu_interrupt;
    logic        idle_over;
    logic        wen_csr;

    int errors;
    int checks;

    csr_top u_csr_top (
        .clk(clk), .aresetn(aresetn), .wen_in(wen_in), .addr_in(addr_in),
        .wdata_in(wdata_in), .d_idle(d_idle), .flush_to_priv_wr_csr(flush_to_priv_wr_csr),
        .exception(exception), .ertn(ertn), .expcode_in(expcode_in),
        .wen_expcode(wen_expcode), .era_in(era_in), .wen_era(wen_era),
        .badv_in(badv_in), .wen_badv(wen_badv), .hardware_interrupt(hardware_interrupt),
        .rdata(rdata), .crmd(crmd), .estat(estat), .era_out(era_out), .eentry(eentry),
        .tid(tid), .cpu_interrupt(cpu_interrupt), .idle_over(idle_over), .wen_csr(wen_csr)
    );

    always #4 clk = ~clk;

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // Status words at the top level mirror their CSRs
    task automatic check_status_port(input string name, input logic [13:0] addr,
                                     input logic [31:0] expected);
        case (addr)
            14'h0:   check_value({name, " crmd port"}, expected, crmd);
            14'h5:   check_value({name, " estat port"}, expected, estat);
            14'h6:   check_value({name, " era port"}, expected, era_out);
            14'hc:   check_value({name, " eentry port"}, expected, eentry);
            14'h40:  check_value({name, " tid port"}, expected, tid);
            default: ;
        endcase
    endtask

    task automatic sample_readback(input string name, input logic [13:0] addr,
                                   input logic [31:0] expected);
        addr_in = addr;
        #2;
        check_value(name, expected, rdata);
        check_status_port(name, addr, expected);
    endtask

    task automatic check_readback(input string name, input logic [13:0] addr,
                                  input logic [31:0] expected);
        next_cycle();
        sample_readback(name, addr, expected);
    endtask

    task automatic wait_idle_cycles(input string name, input int count);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < count) begin
            @(posedge clk);
            cycles++;
            if (d_idle) begin
                seen++;
            end
            if (cycles > IDLE_TIMEOUT) begin
                errors++;
                $display("%s: timed out waiting for %0d idle cycles", name, count);
                break;
            end
        end
        #1;
    endtask

    // Returns one cycle after the capture edge, with the sequencer in HELD
    task automatic capture_write(input logic [13:0] addr, input logic [31:0] data);
        next_cycle();
        wen_in = 1'b1;
        addr_in = addr;
        wdata_in = data;
        next_cycle();
        wen_in = 1'b0;
    endtask

    // New value must be visible right after the third idle edge
    task automatic write_csr(input string name, input logic [13:0] addr,
                             input logic [31:0] data, input logic [31:0] expected);
        capture_write(addr, data);
        check_value({name, " wen_csr"}, 32'h1, {31'b0, wen_csr});
        wait_idle_cycles(name, 3);
        sample_readback(name, addr, expected);
    endtask

    task automatic stalled_write(input string name, input logic [13:0] addr,
                                 input logic [31:0] data, input logic [31:0] old);
        capture_write(addr, data);
        d_idle = 1'b0;
        repeat (6) next_cycle();
        check_value({name, " wen_csr stalled"}, 32'h0, {31'b0, wen_csr});
        check_readback({name, " stalled"}, addr, old);
        next_cycle();
        d_idle = 1'b1;
        wait_idle_cycles(name, 3);
        sample_readback(name, addr, data);
    endtask

    task automatic flushed_write(input string name, input logic [13:0] addr,
                                 input logic [31:0] data, input logic [31:0] old);
        capture_write(addr, data);
        flush_to_priv_wr_csr = 1'b1;
        next_cycle();
        flush_to_priv_wr_csr = 1'b0;
        wait_idle_cycles(name, 3);
        check_readback(name, addr, old);
    endtask

    task automatic raise_exception(input logic [6:0] ecode, input logic [31:0] era);
        next_cycle();
        exception = 1'b1;
        expcode_in = ecode;
        era_in = era;
        wen_era = 1'b1;
        next_cycle();
        exception = 1'b0;
        wen_era = 1'b0;
    endtask

    task automatic return_from_exception();
        next_cycle();
        ertn = 1'b1;
        next_cycle();
        ertn = 1'b0;
    endtask

    // 0 wen_csr, 1 cpu_interrupt, 2 idle_over
    task automatic check_signal(input string name, input logic [1:0] sel,
                                input logic [31:0] expected);
        logic value;
        next_cycle();
        #2;
        case (sel)
            2'd0:    value = wen_csr;
            2'd1:    value = cpu_interrupt;
            default: value = idle_over;
        endcase
        check_value(name, expected, {31'b0, value});
    endtask

    task automatic wait_timer_int(input string name, input int limit);
        int cycles;
        cycles = 0;
        checks++;
        while (!estat[11]) begin
            next_cycle();
            cycles++;
            if (cycles > limit) begin
                errors++;
                $display("%s: timer interrupt did not set within %0d cycles", name, limit);
                break;
            end
        end
    endtask

    task automatic hold_timer_quiet(input string name, input int cycles);
        checks++;
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            if (estat[11]) begin
                errors++;
                $display("%s: timer interrupt set while the timer was disabled", name);
                break;
            end
        end
    endtask

    initial begin
        int          fd;
        int          lineno;
        int          fields;
        string       line;
        string       op;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;

        clk = 1'b0;
        aresetn = 1'b0;
        wen_in = 1'b0;
        addr_in = '0;
        wdata_in = '0;
        d_idle = 1'b1;
        flush_to_priv_wr_csr = 1'b0;
        exception = 1'b0;
        ertn = 1'b0;
        expcode_in = '0;
        wen_expcode = 1'b0;
        era_in = '0;
        wen_era = 1'b0;
        badv_in = '0;
        wen_badv = 1'b0;
        hardware_interrupt = '0;
        errors = 0;
        checks = 0;

        repeat (4) @(posedge clk);
        #1;
        aresetn = 1'b1;

        fd = $fopen("verification/csr_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the trace file verification/csr_trace.txt");
        end else begin
            lineno = 0;
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                lineno++;
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %h %h %h", op, a, d, e);
                if (fields != 4) begin
                    if (fields > 0) begin
                        errors++;
                        $display("line %0d: malformed trace line", lineno);
                    end
                    continue;
                end
                name = $sformatf("line %0d %s %04h", lineno, op, a[13:0]);
                if (op == "W") begin
                    write_csr(name, a[13:0], d, e);
                end else if (op == "R") begin
                    check_readback(name, a[13:0], e);
                end else if (op == "S") begin
                    stalled_write(name, a[13:0], d, e);
                end else if (op == "F") begin
                    flushed_write(name, a[13:0], d, e);
                end else if (op == "EXC") begin
                    raise_exception(a[6:0], d);
                end else if (op == "ERTN") begin
                    return_from_exception();
                end else if (op == "HWI") begin
                    next_cycle();
                    hardware_interrupt = d[7:0];
                end else if (op == "SIG") begin
                    check_signal(name, a[1:0], e);
                end else if (op == "TWAIT") begin
                    wait_timer_int(name, d);
                end else if (op == "TQUIET") begin
                    hold_timer_quiet(name, d);
                end else begin
                    errors++;
                    $display("%s: unknown trace operation", name);
                end
            end
            $fclose(fd);
        end

        if (checks == 0) begin
            errors++;
            $display("no checks were run from the trace file");
        end

        $display("errors %0d, checks %0d", errors, checks);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rtl/csr_top.sv */
module csr_top (
    input  logic                           clk,
    input  logic                           aresetn,
    input  logic                           wen_in,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_in,
    input  logic [csr_pkg::CSR_W-1:0]      wdata_in,
    input  logic                           d_idle,
    input  logic                           flush_to_priv_wr_csr,
    input  logic                           exception,
    input  logic                           ertn,
    input  logic [csr_pkg::ECODE_W:0]      expcode_in,
    input  logic                           wen_expcode,
    input  logic [csr_pkg::CSR_W-1:0]      era_in,
    input  logic                           wen_era,
    input  logic [csr_pkg::CSR_W-1:0]      badv_in,
    input  logic                           wen_badv,
    input  logic [7:0]                     hardware_interrupt,
    output logic [csr_pkg::CSR_W-1:0]      rdata,
    output logic [csr_pkg::CSR_W-1:0]      crmd,
    output logic [csr_pkg::CSR_W-1:0]      estat,
    output logic [csr_pkg::CSR_W-1:0]      era_out,
    output logic [csr_pkg::CSR_W-1:0]      eentry,
    output logic [csr_pkg::CSR_W-1:0]      tid,
    output logic                           cpu_interrupt,
    output logic                           idle_over,
    output logic                           wen_csr
);
    import csr_pkg::*;

    logic                  commit_en;
    logic [CSR_ADDR_W-1:0] commit_addr;
    csr_word_u             commit_data;
    logic                  timer_int;
    logic [CSR_W-1:0]      prmd, ecfg, badv, tcfg, tval;
    logic [CSR_W-1:0]      save0, save1, save2, save3;

    csr_write_seq u_write_seq (
        .clk(clk), .aresetn(aresetn), .wen_in(wen_in), .addr_in(addr_in),
        .wdata_in(wdata_in), .d_idle(d_idle), .flush(flush_to_priv_wr_csr),
        .commit_en(commit_en), .commit_addr(commit_addr), .commit_data(commit_data),
        .wen_csr(wen_csr)
    );

    csr_timer u_timer (
        .clk(clk), .aresetn(aresetn), .commit_en(commit_en), .commit_addr(commit_addr),
        .commit_data(commit_data), .tcfg(tcfg), .tval(tval), .timer_int(timer_int)
    );

    csr_exc_regs u_exc_regs (
        .clk(clk), .aresetn(aresetn), .commit_en(commit_en), .commit_addr(commit_addr),
        .commit_data(commit_data), .exception(exception), .ertn(ertn),
        .expcode_in(expcode_in), .wen_expcode(wen_expcode), .era_in(era_in),
        .wen_era(wen_era), .badv_in(badv_in), .wen_badv(wen_badv),
        .hardware_interrupt(hardware_interrupt), .timer_int(timer_int),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat), .era(era_out),
        .badv(badv), .eentry(eentry), .cpu_interrupt(cpu_interrupt), .idle_over(idle_over)
    );

    csr_save_regs u_save_regs (
        .clk(clk), .aresetn(aresetn), .commit_en(commit_en), .commit_addr(commit_addr),
        .commit_data(commit_data), .save0(save0), .save1(save1), .save2(save2),
        .save3(save3), .tid(tid)
    );

    csr_read_mux u_read_mux (
        .addr_in(addr_in), .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat),
        .era(era_out), .badv(badv), .eentry(eentry), .save0(save0), .save1(save1),
        .save2(save2), .save3(save3), .tid(tid), .tcfg(tcfg), .tval(tval), .rdata(rdata)
    );

endmodule

/* rtl/csr_read_mux.sv */
module csr_read_mux (
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_in,
    input  logic [csr_pkg::CSR_W-1:0]      crmd,
    input  logic [csr_pkg::CSR_W-1:0]      prmd,
    input  logic [csr_pkg::CSR_W-1:0]      ecfg,
    input  logic [csr_pkg::CSR_W-1:0]      estat,
    input  logic [csr_pkg::CSR_W-1:0]      era,
    input  logic [csr_pkg::CSR_W-1:0]      badv,
    input  logic [csr_pkg::CSR_W-1:0]      eentry,
    input  logic [csr_pkg::CSR_W-1:0]      save0,
    input  logic [csr_pkg::CSR_W-1:0]      save1,
    input  logic [csr_pkg::CSR_W-1:0]      save2,
    input  logic [csr_pkg::CSR_W-1:0]      save3,
    input  logic [csr_pkg::CSR_W-1:0]      tid,
    input  logic [csr_pkg::CSR_W-1:0]      tcfg,
    input  logic [csr_pkg::CSR_W-1:0]      tval,
    output logic [csr_pkg::CSR_W-1:0]      rdata
);
    import csr_pkg::*;

    always_comb begin
        case (addr_in)
            CSR_CRMD:   rdata = crmd;
            CSR_PRMD:   rdata = prmd;
            CSR_ECFG:   rdata = ecfg;
            CSR_ESTAT:  rdata = estat;
            CSR_ERA:    rdata = era;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = eentry;
            CSR_SAVE0:  rdata = save0;
            CSR_SAVE1:  rdata = save1;
            CSR_SAVE2:  rdata = save2;
            CSR_SAVE3:  rdata = save3;
            CSR_TID:    rdata = tid;
            CSR_TCFG:   rdata = tcfg;
            CSR_TVAL:   rdata = tval;
            // TICLR is write-only
            CSR_TICLR:  rdata = '0;
            default:    rdata = '0;
        endcase
    end

endmodule

/* rtl/csr_save_regs.sv */
module csr_save_regs (
    input  logic                           clk,
    input  logic                           aresetn,
    input  logic                           commit_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] commit_addr,
    input  csr_pkg::csr_word_u             commit_data,
    output logic [csr_pkg::CSR_W-1:0]      save0,
    output logic [csr_pkg::CSR_W-1:0]      save1,
    output logic [csr_pkg::CSR_W-1:0]      save2,
    output logic [csr_pkg::CSR_W-1:0]      save3,
    output logic [csr_pkg::CSR_W-1:0]      tid
);
    import csr_pkg::*;

    // Plain scratch words, full width writable
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            save0 <= '0;
            save1 <= '0;
            save2 <= '0;
            save3 <= '0;
            tid   <= '0;
        end else if (commit_en) begin
            case (commit_addr)
                CSR_SAVE0: save0 <= commit_data;
                CSR_SAVE1: save1 <= commit_data;
                CSR_SAVE2: save2 <= commit_data;
                CSR_SAVE3: save3 <= commit_data;
                CSR_TID:   tid   <= commit_data;
                default: ;
            endcase
        end
    end

endmodule

/* rtl/csr_exc_regs.sv */
module csr_exc_regs (
    input  logic                           clk,
    input  logic                           aresetn,
    input  logic                           commit_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] commit_addr,
    input  csr_pkg::csr_word_u             commit_data,
    input  logic                           exception,
    input  logic                           ertn,
    input  logic [csr_pkg::ECODE_W:0]      expcode_in,
    input  logic                           wen_expcode,
    input  logic [csr_pkg::CSR_W-1:0]      era_in,
    input  logic                           wen_era,
    input  logic [csr_pkg::CSR_W-1:0]      badv_in,
    input  logic                           wen_badv,
    input  logic [7:0]                     hardware_interrupt,
    input  logic                           timer_int,
    output logic [csr_pkg::CSR_W-1:0]      crmd,
    output logic [csr_pkg::CSR_W-1:0]      prmd,
    output logic [csr_pkg::CSR_W-1:0]      ecfg,
    output logic [csr_pkg::CSR_W-1:0]      estat,
    output logic [csr_pkg::CSR_W-1:0]      era,
    output logic [csr_pkg::CSR_W-1:0]      badv,
    output logic [csr_pkg::CSR_W-1:0]      eentry,
    output logic                           cpu_interrupt,
    output logic                           idle_over
);
    import csr_pkg::*;

    csr_word_u        crmd_r;
    logic [1:0]       prmd_pplv;
    logic             prmd_pie;
    logic [INT_W-1:0] ecfg_lie;
    logic [1:0]       estat_is_soft;
    logic [ECODE_W-1:0] estat_ecode;
    logic             estat_esub;
    logic [25:0]      eentry_va;
    logic [INT_W-1:0] int_pend;
    logic             exc_d;
    logic             exc_enter;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exc_d <= 1'b0;
        end else begin
            exc_d <= exception;
        end
    end

    assign exc_enter = exception && !exc_d;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_r    <= CRMD_RESET;
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (ertn) begin
            crmd_r.crmd.plv <= prmd_pplv;
            crmd_r.crmd.ie  <= prmd_pie;
        end else if (exc_enter) begin
            prmd_pplv       <= crmd_r.crmd.plv;
            prmd_pie        <= crmd_r.crmd.ie;
            crmd_r.crmd.plv <= 2'b0;
            crmd_r.crmd.ie  <= 1'b0;
        end else if (commit_en && commit_addr == CSR_CRMD) begin
            crmd_r.crmd.plv  <= commit_data.crmd.plv;
            crmd_r.crmd.ie   <= commit_data.crmd.ie;
            crmd_r.crmd.datf <= commit_data.crmd.datf;
            crmd_r.crmd.datm <= commit_data.crmd.datm;
            // Only a legal DA/PG pair is taken
            if (commit_data.crmd.da ^ commit_data.crmd.pg) begin
                crmd_r.crmd.da <= commit_data.crmd.da;
                crmd_r.crmd.pg <= commit_data.crmd.pg;
            end
        end else if (commit_en && commit_addr == CSR_PRMD) begin
            prmd_pplv <= commit_data.crmd.plv;
            prmd_pie  <= commit_data.crmd.ie;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie      <= '0;
            estat_is_soft <= 2'b0;
            estat_ecode   <= '0;
            estat_esub    <= 1'b0;
            era           <= '0;
            badv          <= '0;
            eentry_va     <= '0;
        end else begin
            if (commit_en && commit_addr == CSR_ECFG) begin
                ecfg_lie <= commit_data[INT_W-1:0] & ECFG_LIE_MASK;
            end
            if (commit_en && commit_addr == CSR_ESTAT) begin
                estat_is_soft <= commit_data[1:0];
            end
            if (exc_enter || wen_expcode) begin
                estat_ecode <= expcode_in[ECODE_W-1:0];
                // Sub-code is meaningless for interrupts
                estat_esub  <= (expcode_in[ECODE_W-1:0] != '0) && expcode_in[ECODE_W];
            end
            if (wen_era) begin
                era <= era_in;
            end else if (commit_en && commit_addr == CSR_ERA) begin
                era <= commit_data;
            end
            if (wen_badv) begin
                badv <= badv_in;
            end else if (commit_en && commit_addr == CSR_BADV) begin
                badv <= commit_data;
            end
            if (commit_en && commit_addr == CSR_EENTRY) begin
                eentry_va <= commit_data[CSR_W-1:6];
            end
        end
    end

    assign int_pend = {1'b0, timer_int, 1'b0, hardware_interrupt, estat_is_soft};

    assign crmd   = crmd_r;
    assign prmd   = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg   = {{(CSR_W-INT_W){1'b0}}, ecfg_lie};
    assign estat  = {9'b0, estat_esub, estat_ecode, 3'b0, int_pend};
    assign eentry = {eentry_va, 6'b0};

    assign cpu_interrupt = crmd_r.crmd.ie && |(ecfg_lie & int_pend);
    assign idle_over     = |int_pend;

endmodule

/* rtl/csr_timer.sv */
module csr_timer (
    input  logic                           clk,
    input  logic                           aresetn,
    input  logic                           commit_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] commit_addr,
    input  csr_pkg::csr_word_u             commit_data,
    output logic [csr_pkg::CSR_W-1:0]      tcfg,
    output logic [csr_pkg::CSR_W-1:0]      tval,
    output logic                           timer_int
);
    import csr_pkg::*;

    logic                   tcfg_en;
    logic                   tcfg_periodic;
    logic [TCFG_INIT_W-1:0] tcfg_initval;
    logic                   reload;
    logic                   time_out;
    logic                   en_seen;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
            reload        <= 1'b0;
        end else begin
            reload <= commit_en && (commit_addr == CSR_TCFG);
            if (commit_en && (commit_addr == CSR_TCFG)) begin
                tcfg_en       <= commit_data.tcfg.en;
                tcfg_periodic <= commit_data.tcfg.periodic;
                tcfg_initval  <= commit_data.tcfg.initval;
            end
        end
    end

    // Countdown, reload on expiry only in periodic mode
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else if (tval == '0 || reload) begin
            time_out <= 1'b0;
            if (tcfg_periodic || reload) begin
                tval <= {{(CSR_W-TCFG_INIT_W){1'b0}}, tcfg_initval};
            end
        end else if (tcfg_en) begin
            tval     <= tval - 1'b1;
            time_out <= (tval == 1);
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_int <= 1'b0;
            en_seen   <= 1'b0;
        end else begin
            en_seen <= en_seen | tcfg_en;
            if (commit_en && (commit_addr == CSR_TICLR)) begin
                timer_int <= 1'b0;
            end else if (time_out) begin
                timer_int <= 1'b1;
            end
        end
    end

    assign tcfg = {tcfg_initval, tcfg_periodic, tcfg_en};

    a_no_int_without_en: assert property (@(posedge clk) disable iff (!aresetn)
        !en_seen |-> !timer_int);

endmodule

/* rtl/csr_write_seq.sv */
module csr_write_seq (
    input  logic                           clk,
    input  logic                           aresetn,
    input  logic                           wen_in,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_in,
    input  logic [csr_pkg::CSR_W-1:0]      wdata_in,
    input  logic                           d_idle,
    input  logic                           flush,
    output logic                           commit_en,
    output logic [csr_pkg::CSR_ADDR_W-1:0] commit_addr,
    output csr_pkg::csr_word_u             commit_data,
    output logic                           wen_csr
);
    import csr_pkg::*;

    logic [SEQ_STATE_W-1:0] state;
    logic [SEQ_STATE_W-1:0] state_next;

    // One step per decode-idle cycle, a new write restarts the count
    always_comb begin
        state_next = state;
        if (flush) begin
            state_next = SEQ_IDLE;
        end else if (wen_in) begin
            state_next = SEQ_HELD;
        end else if (d_idle) begin
            case (state)
                SEQ_HELD:   state_next = SEQ_WAIT;
                SEQ_WAIT:   state_next = SEQ_COMMIT;
                SEQ_COMMIT: state_next = SEQ_IDLE;
                default:    state_next = SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (wen_in && !flush) begin
            commit_addr <= addr_in;
            commit_data <= wdata_in;
        end
    end

    assign commit_en = (state == SEQ_COMMIT) && d_idle && !flush;
    assign wen_csr   = (state == SEQ_HELD) && d_idle;

    a_single_commit: assert property (@(posedge clk) disable iff (!aresetn)
        commit_en |=> !commit_en);

endmodule

/* rtl/csr_pkg.sv */
package csr_pkg;

    localparam int CSR_W      = 32;
    localparam int CSR_ADDR_W = 14;

    // Exception and mode registers
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h0;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h1;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG   = 14'h4;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h5;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h6;
    localparam logic [CSR_ADDR_W-1:0] CSR_BADV   = 14'h7;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'hc;

    // Scratch and timer registers
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0 = 14'h30;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE1 = 14'h31;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE2 = 14'h32;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE3 = 14'h33;
    localparam logic [CSR_ADDR_W-1:0] CSR_TID   = 14'h40;
    localparam logic [CSR_ADDR_W-1:0] CSR_TCFG  = 14'h41;
    localparam logic [CSR_ADDR_W-1:0] CSR_TVAL  = 14'h42;
    localparam logic [CSR_ADDR_W-1:0] CSR_TICLR = 14'h44;

    // Two soft, eight hard, one reserved, timer at bit 11, IPI at bit 12
    localparam int INT_W = 13;
    localparam logic [INT_W-1:0] ECFG_LIE_MASK = 13'b1_1011_1111_1111;

    localparam int ECODE_W     = 6;
    localparam int TCFG_INIT_W = 30;

    // DA=1, DATF=1, DATM=1
    localparam logic [CSR_W-1:0] CRMD_RESET = 32'h0000_00a8;

    // Write sequencer states
    localparam int SEQ_STATE_W = 2;
    localparam logic [SEQ_STATE_W-1:0] SEQ_IDLE   = 2'd0;
    localparam logic [SEQ_STATE_W-1:0] SEQ_HELD   = 2'd1;
    localparam logic [SEQ_STATE_W-1:0] SEQ_WAIT   = 2'd2;
    localparam logic [SEQ_STATE_W-1:0] SEQ_COMMIT = 2'd3;

    typedef union packed {
        struct packed {
            logic [22:0] rsvd;
            logic [1:0]  datm;
            logic [1:0]  datf;
            logic        pg;
            logic        da;
            logic        ie;
            logic [1:0]  plv;
        } crmd;
        struct packed {
            logic [TCFG_INIT_W-1:0] initval;
            logic                   periodic;
            logic                   en;
        } tcfg;
    } csr_word_u;

endpackage
